// ==== exceptionArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module exceptionArbiter (
    memLaneIf.drain lanes [memStagePkg::LANES],
    output memStagePkg::execData_t memOut [memStagePkg::LANES],
    output memStagePkg::dbusReq_t dreq [memStagePkg::LANES]
);
    import memStagePkg::*;

    // higher index is older; set when any older lane faults
    logic [LANES-1:0] squash;

    for (genvar g = 0; g < LANES; g++) begin : gLane
        if (g == LANES - 1) begin : gOldest
            // nothing ahead of the oldest lane
            assign squash[g] = 1'b0;
        end else begin : gYounger
            assign squash[g] = squash[g + 1] | lanes[g + 1].fault;
        end

        always_comb begin
            memOut[g] = lanes[g].result;
            dreq[g] = lanes[g].req;
            if (squash[g]) begin
                // kill every architectural side effect
                memOut[g].ctl.regwrite = 1'b0;
                memOut[g].ctl.memtoreg = 1'b0;
                memOut[g].ctl.memwrite = 1'b0;
                memOut[g].ctl.lowrite = 1'b0;
                memOut[g].ctl.hiwrite = 1'b0;
                memOut[g].ctl.cp0write = 1'b0;
                memOut[g].cp0Ctl.valid = 1'b0;
                dreq[g].valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== issueLatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueLatch (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic flush,
    input  memStagePkg::execData_t in [memStagePkg::LANES],
    memLaneIf.feed lanes [memStagePkg::LANES]
);
    import memStagePkg::*;

    for (genvar g = 0; g < LANES; g++) begin : gLane
        execData_t capture;

        // a bubble enters with no control flags set
        always_comb begin
            capture = in[g];
            if (!in[g].valid) begin
                capture.ctl = '0;
            end
        end

        // flush wins over stall
        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                lanes[g].data <= '0;
            end else if (flush) begin
                lanes[g].data.valid <= 1'b0;
                lanes[g].data.cp0Ctl <= '0;
            end else if (!stall) begin
                lanes[g].data <= capture;
            end
        end
    end

endmodule

`default_nettype wire

// ==== memLane.sv ====
`timescale 1ns/1ps
`default_nettype none

module memLane (
    memLaneIf.lane io
);
    import memStagePkg::*;

    word_t paddr;
    word_t storeData;
    strobe_t storeStrobe;
    logic sizeMisalign;
    logic isLoad;
    logic isStore;
    logic storeFault;
    logic loadFault;
    cp0Ctl_t cp0Out;

    // kseg0/kseg1 are unmapped, just drop the top three bits
    assign paddr = (io.data.aluOut[31:30] == KSEG_SEL)
                   ? (io.data.aluOut & ~KSEG_MASK)
                   : io.data.aluOut;

    // same size rule serves loads and stores
    storeAlign uAlign (
        .addrLow (io.data.aluOut[1:0]),
        .rawData (io.data.srcb),
        .size    (io.data.ctl.msize),
        .data    (storeData),
        .strobe  (storeStrobe),
        .misalign(sizeMisalign)
    );

    assign isLoad = io.data.valid && io.data.ctl.memtoreg;
    assign isStore = io.data.valid && io.data.ctl.memwrite;
    assign storeFault = isStore && sizeMisalign;
    assign loadFault = isLoad && sizeMisalign;

    // an exception from an earlier stage takes precedence
    always_comb begin
        cp0Out = io.data.cp0Ctl;
        if (!io.data.cp0Ctl.valid) begin
            if (storeFault) begin
                cp0Out.valid = 1'b1;
                cp0Out.ctype = EXCEPTION;
                cp0Out.etype.adesD = 1'b1;
            end else if (loadFault) begin
                cp0Out.valid = 1'b1;
                cp0Out.ctype = EXCEPTION;
                cp0Out.etype.adelD = 1'b1;
            end
        end
    end

    // aluOut stays virtual for the exception handler
    always_comb begin
        io.result = io.data;
        io.result.cp0Ctl = cp0Out;
    end

    assign io.fault = cp0Out.valid;

    always_comb begin
        io.req = '0;
        if (isLoad || isStore) begin
            io.req.valid = !cp0Out.valid;
            io.req.addr = paddr;
            io.req.size = io.data.ctl.msize;
            if (isStore) begin
                io.req.data = storeData;
                io.req.strobe = storeStrobe;
            end
        end
    end

endmodule

`default_nettype wire

// ==== memLaneIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface memLaneIf;
    import memStagePkg::*;

    // instruction held in the stage register
    execData_t data;

    // instruction after exception marking, before cross-lane squash
    execData_t result;

    // candidate data-bus request
    dbusReq_t req;

    // lane carries an exception, incoming or from misalignment
    logic fault;

    modport feed (
        output data
    );

    modport lane (
        input  data,
        output result,
        output req,
        output fault
    );

    modport drain (
        input result,
        input req,
        input fault
    );

endinterface

`default_nettype wire

// ==== memStage.f ====
memStagePkg.sv
memLaneIf.sv
storeAlign.sv
memLane.sv
issueLatch.sv
exceptionArbiter.sv
memStage.sv
memStageTb.sv

// ==== memStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStage (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic flush,
    input  memStagePkg::execData_t execIn0,
    input  memStagePkg::execData_t execIn1,
    output memStagePkg::execData_t memOut0,
    output memStagePkg::execData_t memOut1,
    output memStagePkg::dbusReq_t dreq0,
    output memStagePkg::dbusReq_t dreq1
);
    import memStagePkg::*;

    execData_t laneIn [LANES];
    execData_t laneOut [LANES];
    dbusReq_t laneReq [LANES];

    memLaneIf laneBus [LANES] ();

    // index 1 carries the older instruction
    assign laneIn[0] = execIn0;
    assign laneIn[1] = execIn1;

    issueLatch uLatch (
        .clk  (clk),
        .rstN (rstN),
        .stall(stall),
        .flush(flush),
        .in   (laneIn),
        .lanes(laneBus)
    );

    for (genvar g = 0; g < LANES; g++) begin : gLane
        memLane uLane (
            .io(laneBus[g])
        );
    end

    exceptionArbiter uArbiter (
        .lanes (laneBus),
        .memOut(laneOut),
        .dreq  (laneReq)
    );

    assign memOut0 = laneOut[0];
    assign memOut1 = laneOut[1];
    assign dreq0 = laneReq[0];
    assign dreq1 = laneReq[1];

endmodule

`default_nettype wire

// ==== memStagePkg.sv ====
`default_nettype none

package memStagePkg;

    // number of instructions issued per cycle
    localparam int LANES = 2;

    // upper address bits dropped by kseg0/kseg1 translation
    localparam logic [31:0] KSEG_MASK = 32'hE000_0000;

    // top two bits shared by kseg0 (100) and kseg1 (101)
    localparam logic [1:0] KSEG_SEL = 2'b10;

    typedef logic [31:0] word_t;
    typedef logic [3:0] strobe_t;

    typedef enum logic [1:0] {
        MSIZE1,
        MSIZE2,
        MSIZE4
    } msize_e;

    typedef struct packed {
        logic regwrite;
        logic memtoreg;
        logic memwrite;
        logic lowrite;
        logic hiwrite;
        logic cp0write;
        msize_e msize;
    } ctl_t;

    // address error on load / store
    typedef struct packed {
        logic adelD;
        logic adesD;
    } excType_t;

    typedef enum logic {
        NONE,
        EXCEPTION
    } cp0Type_e;

    typedef struct packed {
        logic valid;
        cp0Type_e ctype;
        excType_t etype;
    } cp0Ctl_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        logic [4:0] rdst;
        ctl_t ctl;
        // virtual address for loads and stores
        word_t aluOut;
        word_t srcb;
        cp0Ctl_t cp0Ctl;
        logic isSlot;
    } execData_t;

    typedef struct packed {
        logic valid;
        word_t addr;
        msize_e size;
        word_t data;
        strobe_t strobe;
    } dbusReq_t;

endpackage

`default_nettype wire

// ==== memStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStageTb;
    import memStagePkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int TEST_CYCLES = 2000;
    localparam int MARGIN_CYCLES = 50;
    localparam int CYCLE_LIMIT = RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES;
    localparam int DIRECTED_CYCLES = 6;

    logic clk;
    logic rstN;
    logic stall;
    logic flush;
    execData_t execIn0;
    execData_t execIn1;
    execData_t memOut0;
    execData_t memOut1;
    dbusReq_t dreq0;
    dbusReq_t dreq1;

    // model of the stage register (index 1 is older)
    execData_t refReg [LANES];
    execData_t expOut0;
    execData_t expOut1;
    dbusReq_t expReq0;
    dbusReq_t expReq1;
    logic started;
    int cycleCount;
    integer seed;

    memStage uut (
        .clk    (clk),
        .rstN   (rstN),
        .stall  (stall),
        .flush  (flush),
        .execIn0(execIn0),
        .execIn1(execIn1),
        .memOut0(memOut0),
        .memOut1(memOut1),
        .dreq0  (dreq0),
        .dreq1  (dreq1)
    );

    always #2 clk = ~clk;

    task automatic stopOnFailure();
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkExec(input string name, input execData_t got, input execData_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            stopOnFailure();
        end
    endtask

    // address, data and strobe only matter on a live request
    task automatic checkReq(input string name, input dbusReq_t got, input dbusReq_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            stopOnFailure();
        end
    endtask

    function automatic word_t physAddr(input word_t va);
        word_t pa;
        pa = va;
        // kseg0 and kseg1 map straight onto the low 512 MB
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
            pa[31:29] = 3'b000;
        end
        return pa;
    endfunction

    function automatic logic badAlign(input msize_e size, input logic [1:0] low);
        return (size == MSIZE2 && low[0]) || (size == MSIZE4 && low != 2'b00);
    endfunction

    function automatic strobe_t byteEnables(input msize_e size, input logic [1:0] low);
        strobe_t s;
        s = 4'b0000;
        if (!badAlign(size, low)) begin
            case (size)
                MSIZE1: s[low] = 1'b1;
                MSIZE2: begin
                    s[low] = 1'b1;
                    s[low + 2'd1] = 1'b1;
                end
                default: s = 4'b1111;
            endcase
        end
        return s;
    endfunction

    function automatic word_t replicate(input msize_e size, input word_t v);
        case (size)
            MSIZE1: return {v[7:0], v[7:0], v[7:0], v[7:0]};
            MSIZE2: return {v[15:0], v[15:0]};
            default: return v;
        endcase
    endfunction

    function automatic execData_t captured(input execData_t e);
        execData_t c;
        c = e;
        if (!e.valid) begin
            c.ctl = '0;
        end
        return c;
    endfunction

    // one lane on its own before the cross-lane squash
    function automatic void laneExpect(input execData_t s, output execData_t o,
                                       output dbusReq_t r, output logic fault);
        logic mis;
        mis = badAlign(s.ctl.msize, s.aluOut[1:0]);
        o = s;
        if (!s.cp0Ctl.valid && s.valid && mis) begin
            if (s.ctl.memwrite) begin
                o.cp0Ctl.valid = 1'b1;
                o.cp0Ctl.ctype = EXCEPTION;
                o.cp0Ctl.etype.adesD = 1'b1;
            end else if (s.ctl.memtoreg) begin
                o.cp0Ctl.valid = 1'b1;
                o.cp0Ctl.ctype = EXCEPTION;
                o.cp0Ctl.etype.adelD = 1'b1;
            end
        end
        fault = o.cp0Ctl.valid;
        r = '0;
        if (s.valid && (s.ctl.memtoreg || s.ctl.memwrite)) begin
            r.valid = !fault;
            r.addr = physAddr(s.aluOut);
            r.size = s.ctl.msize;
            if (s.ctl.memwrite) begin
                r.data = replicate(s.ctl.msize, s.srcb);
                r.strobe = byteEnables(s.ctl.msize, s.aluOut[1:0]);
            end
        end
    endfunction

    function automatic void refStage(input execData_t older, input execData_t younger,
                                     output execData_t outOld, output execData_t outYoung,
                                     output dbusReq_t reqOld, output dbusReq_t reqYoung);
        logic oldFault;
        logic youngFault;
        laneExpect(older, outOld, reqOld, oldFault);
        laneExpect(younger, outYoung, reqYoung, youngFault);
        if (oldFault) begin
            outYoung.ctl.regwrite = 1'b0;
            outYoung.ctl.memtoreg = 1'b0;
            outYoung.ctl.memwrite = 1'b0;
            outYoung.ctl.lowrite = 1'b0;
            outYoung.ctl.hiwrite = 1'b0;
            outYoung.ctl.cp0write = 1'b0;
            outYoung.cp0Ctl.valid = 1'b0;
            reqYoung.valid = 1'b0;
        end
    endfunction

    task automatic makeAccess(output execData_t e, input logic store, input msize_e size,
                              input word_t addr, input word_t value);
        e = '0;
        e.valid = 1'b1;
        e.pc = 32'hBFC0_0000 ^ addr;
        e.rdst = 5'd8;
        e.ctl.msize = size;
        e.ctl.memwrite = store;
        e.ctl.memtoreg = !store;
        e.ctl.regwrite = !store;
        e.aluOut = addr;
        e.srcb = value;
    endtask

    task automatic makeRandom(output execData_t e);
        int kind;
        int region;
        int sizeCode;
        e = '0;
        e.valid = ($random(seed) & 3) != 0;
        e.pc = $random(seed);
        e.rdst = 5'($random(seed));
        e.srcb = $random(seed);
        e.isSlot = 1'($random(seed));
        sizeCode = {$random(seed)} % 3;
        case (sizeCode)
            0: e.ctl.msize = MSIZE1;
            1: e.ctl.msize = MSIZE2;
            default: e.ctl.msize = MSIZE4;
        endcase
        kind = {$random(seed)} % 3;
        if (kind == 0) begin
            e.ctl.memtoreg = 1'b1;
            e.ctl.regwrite = 1'b1;
        end else if (kind == 1) begin
            e.ctl.memwrite = 1'b1;
        end else begin
            e.ctl.regwrite = 1'($random(seed));
            e.ctl.lowrite = 1'($random(seed));
            e.ctl.hiwrite = 1'($random(seed));
            e.ctl.cp0write = 1'($random(seed));
        end
        // mostly kseg0/kseg1
        e.aluOut = $random(seed);
        region = {$random(seed)} % 4;
        if (region == 0) begin
            e.aluOut[31:29] = 3'b100;
        end else if (region == 1) begin
            e.aluOut[31:29] = 3'b101;
        end else if (region == 2) begin
            e.aluOut[31:29] = 3'b000;
        end
        // low bits left random two times in three
        if ({$random(seed)} % 3 == 0) begin
            e.aluOut[1:0] = 2'b00;
        end
        if ({$random(seed)} % 16 == 0) begin
            e.cp0Ctl.valid = 1'b1;
            e.cp0Ctl.ctype = EXCEPTION;
            e.cp0Ctl.etype = 2'($random(seed));
        end
    endtask

    // compare first and then advance the model as the latch would
    always @(posedge clk) begin
        if (started) begin
            refStage(refReg[1], refReg[0], expOut1, expOut0, expReq1, expReq0);
            checkExec("memOut1", memOut1, expOut1);
            checkExec("memOut0", memOut0, expOut0);
            checkReq("dreq1", dreq1, expReq1);
            checkReq("dreq0", dreq0, expReq0);
        end
        started = 1'b1;
        if (!rstN) begin
            for (int i = 0; i < LANES; i++) begin
                refReg[i] = '0;
            end
        end else if (flush) begin
            for (int i = 0; i < LANES; i++) begin
                refReg[i].valid = 1'b0;
                refReg[i].cp0Ctl = '0;
            end
        end else if (!stall) begin
            refReg[0] = captured(execIn0);
            refReg[1] = captured(execIn1);
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stopOnFailure();
        end
    end

    initial begin
        seed = 77064;
        started = 1'b0;
        cycleCount = 0;
        clk = 1'b0;
        rstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        execIn0 = '0;
        execIn1 = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;

        // aligned word store in kseg1 next to an aligned half load in kseg0
        makeAccess(execIn1, 1'b1, MSIZE4, 32'hA000_1000, 32'h1234_5678);
        makeAccess(execIn0, 1'b0, MSIZE2, 32'h8000_2002, 32'h0);
        @(negedge clk);
        // misaligned older load squashes a younger byte store
        makeAccess(execIn1, 1'b0, MSIZE4, 32'h8000_0001, 32'h0);
        makeAccess(execIn0, 1'b1, MSIZE1, 32'h0000_0043, 32'h0000_00A5);
        @(negedge clk);
        // younger misaligned half store and older byte load outside kseg
        makeAccess(execIn1, 1'b0, MSIZE1, 32'hC000_0007, 32'h0);
        makeAccess(execIn0, 1'b1, MSIZE2, 32'h0000_0103, 32'h0000_BEEF);
        @(negedge clk);
        // exception arriving with the older instruction
        makeAccess(execIn1, 1'b0, MSIZE4, 32'h8000_0010, 32'h0);
        execIn1.cp0Ctl.valid = 1'b1;
        execIn1.cp0Ctl.ctype = EXCEPTION;
        execIn1.cp0Ctl.etype.adelD = 1'b1;
        makeAccess(execIn0, 1'b1, MSIZE4, 32'h8000_0020, 32'hCAFE_F00D);
        @(negedge clk);
        stall = 1'b1;
        makeAccess(execIn1, 1'b1, MSIZE1, 32'h8000_0031, 32'h0000_005A);
        @(negedge clk);
        stall = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;

        for (int n = 0; n < TEST_CYCLES - DIRECTED_CYCLES; n++) begin
            makeRandom(execIn0);
            makeRandom(execIn1);
            stall = ({$random(seed)} % 8) == 0;
            flush = ({$random(seed)} % 16) == 0;
            @(negedge clk);
        end

        // let the last captured pair reach the compare
        stall = 1'b0;
        flush = 1'b0;
        execIn0 = '0;
        execIn1 = '0;
        repeat (2) @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== storeAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeAlign (
    input  logic [1:0] addrLow,
    input  memStagePkg::word_t rawData,
    input  memStagePkg::msize_e size,
    output memStagePkg::word_t data,
    output memStagePkg::strobe_t strobe,
    output logic misalign
);
    import memStagePkg::*;

    always_comb begin
        data = rawData;
        strobe = '0;
        misalign = 1'b0;
        case (size)
            MSIZE1: begin
                // byte lane picked by the low address bits
                data = {4{rawData[7:0]}};
                strobe = strobe_t'(4'b0001 << addrLow);
            end
            MSIZE2: begin
                data = {2{rawData[15:0]}};
                misalign = addrLow[0];
                strobe = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            MSIZE4: begin
                misalign = (addrLow != 2'b00);
                strobe = 4'b1111;
            end
            default: begin
                // unused size code writes nothing
                strobe = '0;
            end
        endcase

        // no bytes written on a misaligned access
        if (misalign) begin
            strobe = '0;
        end
    end

endmodule

`default_nettype wire
